// File: verilog/udp_pkg.sv
`default_nettype none

package udp_pkg;

    // One stream beat, last marks the final beat of a packet
    typedef struct packed {
        logic [63:0] data;
        logic        last;
    } udp_beat_t;

    // Layout of a header beat, most significant field first
    typedef struct packed {
        logic [31:0] src_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
    } udp_hdr_t;

    // Low 16 bits of an accepted qword
    typedef logic [15:0] acknack_t;

    localparam int NUM_HANDLER = 2;

    // 'Ta' and 'Tn'
    localparam logic [15:0] ACK_PORT  = 16'd21601;
    localparam logic [15:0] NACK_PORT = 16'd21614;

    // Any of these bits set in a qword rejects it
    localparam logic [63:0] ACK_CHECK_MASK  = 64'h800000FF_FFF00000;
    localparam logic [63:0] NACK_CHECK_MASK = 64'h000000FF_FFFFFFFF;

    // Entry 0 is the ack handler, entry 1 the nack handler
    localparam logic [NUM_HANDLER-1:0][15:0] HANDLER_PORTS = {
        NACK_PORT,
        ACK_PORT
    };
    localparam logic [NUM_HANDLER-1:0][63:0] HANDLER_MASKS = {
        NACK_CHECK_MASK,
        ACK_CHECK_MASK
    };

    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        PAYLOAD,
        RESP_HDR,
        RESP_CNT
    } handler_state_e;

endpackage

`default_nettype wire

// File: verilog/udp_port_switch.sv
`timescale 1ns/1ns
`default_nettype none

module udp_port_switch #(
    parameter int                           NUM_HANDLER   = 2,
    parameter logic [NUM_HANDLER-1:0][15:0] HANDLER_PORTS = '0
) (
    input  wire                     clk156,
    input  wire                     arst_n_i,
    input  wire udp_pkg::udp_beat_t in_beat_i,
    input  wire                     in_valid_i,
    output logic                    in_ready_o,
    output udp_pkg::udp_beat_t      hnd_beat_o [NUM_HANDLER],
    output logic [NUM_HANDLER-1:0]  hnd_valid_o,
    input  wire  [NUM_HANDLER-1:0]  hnd_ready_i
);

    localparam int IDX_W = (NUM_HANDLER > 1) ? $clog2(NUM_HANDLER) : 1;

    udp_pkg::udp_hdr_t hdr;
    logic              in_hdr_q;
    logic              sel_hit_q;
    logic [IDX_W-1:0]  sel_q;
    logic              match_hit;
    logic [IDX_W-1:0]  match_idx;
    logic              tgt_hit;
    logic [IDX_W-1:0]  tgt_idx;
    logic              in_xfer;

    assign hdr = in_beat_i.data;

    // Lowest matching entry wins
    always_comb begin
        match_hit = 1'b0;
        match_idx = '0;
        for (int i = NUM_HANDLER - 1; i >= 0; i--) begin
            if (hdr.dst_port == HANDLER_PORTS[i]) begin
                match_hit = 1'b1;
                match_idx = IDX_W'(i);
            end
        end
    end

    // Header beats decode live, later beats follow the latched choice
    assign tgt_hit = in_hdr_q ? match_hit : sel_hit_q;
    assign tgt_idx = in_hdr_q ? match_idx : sel_q;

    // Unmatched packets are always taken and dropped
    assign in_ready_o = !tgt_hit || !hnd_valid_o[tgt_idx] || hnd_ready_i[tgt_idx];
    assign in_xfer    = in_valid_i && in_ready_o;

    always_ff @(posedge clk156 or negedge arst_n_i) begin
        if (!arst_n_i) begin
            in_hdr_q  <= 1'b1;
            sel_hit_q <= 1'b0;
            sel_q     <= '0;
        end else if (in_xfer) begin
            in_hdr_q <= in_beat_i.last;
            if (in_hdr_q) begin
                sel_hit_q <= match_hit;
                sel_q     <= match_idx;
            end
        end
    end

    // One output register per handler path
    for (genvar g = 0; g < NUM_HANDLER; g++) begin : gen_out
        logic               load;
        logic               valid_q;
        udp_pkg::udp_beat_t beat_q;

        assign load = in_xfer && tgt_hit && (tgt_idx == IDX_W'(g));

        always_ff @(posedge clk156 or negedge arst_n_i) begin
            if (!arst_n_i) begin
                valid_q <= 1'b0;
            end else if (load) begin
                valid_q <= 1'b1;
            end else if (hnd_ready_i[g]) begin
                valid_q <= 1'b0;
            end
        end

        always_ff @(posedge clk156) begin
            if (load) begin
                beat_q <= in_beat_i;
            end
        end

        assign hnd_valid_o[g] = valid_q;
        assign hnd_beat_o[g]  = beat_q;
    end

endmodule

`default_nettype wire

// File: verilog/acknack_port.sv
`timescale 1ns/1ns
`default_nettype none

module acknack_port #(
    parameter logic [15:0] HANDLER_PORT = udp_pkg::ACK_PORT,
    parameter logic [63:0] CHECK_MASK   = udp_pkg::ACK_CHECK_MASK
) (
    input  wire                     clk156,
    input  wire                     arst_n_i,
    input  wire                     event_open_i,
    input  wire udp_pkg::udp_beat_t req_beat_i,
    input  wire                     req_valid_i,
    output logic                    req_ready_o,
    output udp_pkg::udp_beat_t      resp_beat_o,
    output logic                    resp_valid_o,
    input  wire                     resp_ready_i,
    output udp_pkg::acknack_t       acknack_o,
    output logic                    acknack_valid_o,
    input  wire                     acknack_ready_i
);

    udp_pkg::handler_state_e state_q;
    udp_pkg::udp_hdr_t       req_hdr;
    udp_pkg::udp_hdr_t       resp_hdr;
    logic [31:0]             src_ip_q;
    logic [15:0]             src_port_q;
    logic [15:0]             count_q;
    logic                    ack_free;
    logic                    req_xfer;
    logic                    qword_ok;
    logic                    ack_load;

    assign req_hdr  = req_beat_i.data;
    assign ack_free = !acknack_valid_o || acknack_ready_i;
    assign qword_ok = event_open_i && ((req_beat_i.data & CHECK_MASK) == 64'd0);

    // Payload stalls while the acknack word is stuck
    always_comb begin
        case (state_q)
            udp_pkg::HEADER:  req_ready_o = 1'b1;
            udp_pkg::PAYLOAD: req_ready_o = ack_free;
            default:          req_ready_o = 1'b0;
        endcase
    end

    assign req_xfer = req_valid_i && req_ready_o;
    assign ack_load = (state_q == udp_pkg::PAYLOAD) && req_xfer && qword_ok;

    always_ff @(posedge clk156 or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= udp_pkg::IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                udp_pkg::IDLE: begin
                    count_q <= '0;
                    if (req_valid_i) begin
                        state_q <= udp_pkg::HEADER;
                    end
                end
                udp_pkg::HEADER: begin
                    if (req_xfer) begin
                        state_q <= req_beat_i.last ? udp_pkg::RESP_HDR : udp_pkg::PAYLOAD;
                    end
                end
                udp_pkg::PAYLOAD: begin
                    if (ack_load) begin
                        count_q <= count_q + 16'd1;
                    end
                    if (req_xfer && req_beat_i.last) begin
                        state_q <= udp_pkg::RESP_HDR;
                    end
                end
                udp_pkg::RESP_HDR: begin
                    if (resp_ready_i) begin
                        state_q <= udp_pkg::RESP_CNT;
                    end
                end
                udp_pkg::RESP_CNT: begin
                    if (resp_ready_i) begin
                        state_q <= udp_pkg::IDLE;
                    end
                end
                default: state_q <= udp_pkg::IDLE;
            endcase
        end
    end

    // Sender address for the reply
    always_ff @(posedge clk156) begin
        if (state_q == udp_pkg::HEADER && req_xfer) begin
            src_ip_q   <= req_hdr.src_ip;
            src_port_q <= req_hdr.src_port;
        end
    end

    always_ff @(posedge clk156 or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acknack_valid_o <= 1'b0;
        end else if (ack_load) begin
            acknack_valid_o <= 1'b1;
        end else if (acknack_ready_i) begin
            acknack_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk156) begin
        if (ack_load) begin
            acknack_o <= req_beat_i.data[15:0];
        end
    end

    // Reply goes back to where the request came from
    assign resp_hdr = '{src_ip: src_ip_q, src_port: HANDLER_PORT, dst_port: src_port_q};

    assign resp_valid_o     = (state_q == udp_pkg::RESP_HDR) || (state_q == udp_pkg::RESP_CNT);
    assign resp_beat_o.last = (state_q == udp_pkg::RESP_CNT);
    assign resp_beat_o.data = (state_q == udp_pkg::RESP_CNT) ? {48'd0, count_q} : resp_hdr;

endmodule

`default_nettype wire

// File: verilog/udp_port_mux.sv
`timescale 1ns/1ns
`default_nettype none

module udp_port_mux #(
    parameter int NUM_HANDLER = 2
) (
    input  wire                     clk156,
    input  wire                     arst_n_i,
    input  wire udp_pkg::udp_beat_t resp_beat_i [NUM_HANDLER],
    input  wire  [NUM_HANDLER-1:0]  resp_valid_i,
    output logic [NUM_HANDLER-1:0]  resp_ready_o,
    output udp_pkg::udp_beat_t      out_beat_o,
    output logic                    out_valid_o,
    input  wire                     out_ready_i
);

    localparam int IDX_W = (NUM_HANDLER > 1) ? $clog2(NUM_HANDLER) : 1;

    logic             active_q;
    logic [IDX_W-1:0] grant_q;
    logic [IDX_W-1:0] last_q;
    logic             pick_hit;
    logic [IDX_W-1:0] pick_idx;
    logic [IDX_W-1:0] cur;

    // Search starts just after the last winner, which comes last
    always_comb begin
        int unsigned idx;
        pick_hit = 1'b0;
        pick_idx = '0;
        idx      = 0;
        for (int k = NUM_HANDLER; k >= 1; k--) begin
            idx = (int'(last_q) + k) % NUM_HANDLER;
            if (resp_valid_i[idx]) begin
                pick_hit = 1'b1;
                pick_idx = IDX_W'(idx);
            end
        end
    end

    assign cur         = active_q ? grant_q : pick_idx;
    assign out_valid_o = active_q ? resp_valid_i[grant_q] : pick_hit;
    assign out_beat_o  = resp_beat_i[cur];

    always_comb begin
        resp_ready_o      = '0;
        resp_ready_o[cur] = out_valid_o && out_ready_i;
    end

    // Lock the grant as soon as a beat is offered, release on the last transfer
    always_ff @(posedge clk156 or negedge arst_n_i) begin
        if (!arst_n_i) begin
            active_q <= 1'b0;
            grant_q  <= '0;
            last_q   <= IDX_W'(NUM_HANDLER - 1);
        end else if (out_valid_o) begin
            if (out_ready_i && out_beat_o.last) begin
                active_q <= 1'b0;
                last_q   <= cur;
            end else begin
                active_q <= 1'b1;
                grant_q  <= cur;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/turf_acknack_top.sv
`timescale 1ns/1ns
`default_nettype none

module turf_acknack_top #(
    parameter int NUM_HANDLER = udp_pkg::NUM_HANDLER
) (
    input  wire                     clk156,
    input  wire                     arst_n_i,
    input  wire                     event_open_i,
    input  wire udp_pkg::udp_beat_t in_beat_i,
    input  wire                     in_valid_i,
    output wire                     in_ready_o,
    output wire udp_pkg::udp_beat_t out_beat_o,
    output wire                     out_valid_o,
    input  wire                     out_ready_i,
    output wire udp_pkg::acknack_t  ack_o [NUM_HANDLER],
    output wire [NUM_HANDLER-1:0]   ack_valid_o,
    input  wire [NUM_HANDLER-1:0]   ack_ready_i
);

    // Switch to handlers
    wire udp_pkg::udp_beat_t hnd_beat [NUM_HANDLER];
    wire [NUM_HANDLER-1:0]   hnd_valid;
    wire [NUM_HANDLER-1:0]   hnd_ready;

    // Handlers to mux
    wire udp_pkg::udp_beat_t resp_beat [NUM_HANDLER];
    wire [NUM_HANDLER-1:0]   resp_valid;
    wire [NUM_HANDLER-1:0]   resp_ready;

    udp_port_switch #(
        .NUM_HANDLER   (NUM_HANDLER),
        .HANDLER_PORTS (udp_pkg::HANDLER_PORTS[NUM_HANDLER-1:0])
    ) u_switch (
        .clk156      (clk156),
        .arst_n_i    (arst_n_i),
        .in_beat_i   (in_beat_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .hnd_beat_o  (hnd_beat),
        .hnd_valid_o (hnd_valid),
        .hnd_ready_i (hnd_ready)
    );

    // Ack and nack handlers differ only in port and check mask
    for (genvar i = 0; i < NUM_HANDLER; i++) begin : gen_handler
        acknack_port #(
            .HANDLER_PORT (udp_pkg::HANDLER_PORTS[i]),
            .CHECK_MASK   (udp_pkg::HANDLER_MASKS[i])
        ) u_handler (
            .clk156          (clk156),
            .arst_n_i        (arst_n_i),
            .event_open_i    (event_open_i),
            .req_beat_i      (hnd_beat[i]),
            .req_valid_i     (hnd_valid[i]),
            .req_ready_o     (hnd_ready[i]),
            .resp_beat_o     (resp_beat[i]),
            .resp_valid_o    (resp_valid[i]),
            .resp_ready_i    (resp_ready[i]),
            .acknack_o       (ack_o[i]),
            .acknack_valid_o (ack_valid_o[i]),
            .acknack_ready_i (ack_ready_i[i])
        );
    end

    udp_port_mux #(
        .NUM_HANDLER (NUM_HANDLER)
    ) u_mux (
        .clk156       (clk156),
        .arst_n_i     (arst_n_i),
        .resp_beat_i  (resp_beat),
        .resp_valid_i (resp_valid),
        .resp_ready_o (resp_ready),
        .out_beat_o   (out_beat_o),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i)
    );

endmodule

`default_nettype wire

// File: tb/acknack_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module acknack_asserts #(
    parameter int NUM_HANDLER = 2
) (
    input wire                     clk156,
    input wire                     arst_n_i,
    input wire udp_pkg::udp_beat_t out_beat_o,
    input wire                     out_valid_o,
    input wire                     out_ready_i,
    input wire udp_pkg::acknack_t  ack_o [NUM_HANDLER],
    input wire [NUM_HANDLER-1:0]   ack_valid_o,
    input wire [NUM_HANDLER-1:0]   ack_ready_i
);

    // A stalled outbound beat stays put until taken
    out_hold: assert property (
        @(posedge clk156) disable iff (!arst_n_i)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_beat_o))
    ) else $error("outbound beat changed while stalled");

    for (genvar i = 0; i < NUM_HANDLER; i++) begin : gen_ack
        ack_hold: assert property (
            @(posedge clk156) disable iff (!arst_n_i)
            (ack_valid_o[i] && !ack_ready_i[i]) |=> (ack_valid_o[i] && $stable(ack_o[i]))
        ) else $error("acknack word %0d changed while stalled", i);
    end

endmodule

bind turf_acknack_top acknack_asserts #(
    .NUM_HANDLER (NUM_HANDLER)
) u_asserts (
    .clk156      (clk156),
    .arst_n_i    (arst_n_i),
    .out_beat_o  (out_beat_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .ack_o       (ack_o),
    .ack_valid_o (ack_valid_o),
    .ack_ready_i (ack_ready_i)
);

`default_nettype wire

// File: tb/tb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_top;

    localparam int          NUM_HANDLER    = udp_pkg::NUM_HANDLER;
    localparam int          TIMEOUT_CYCLES = 20000;
    localparam logic [31:0] SEED           = 32'h4529d7b2;

    logic                   clk156;
    logic                   arst_n_i;
    logic                   event_open_i;
    udp_pkg::udp_beat_t     in_beat_i;
    logic                   in_valid_i;
    wire                    in_ready_o;
    wire udp_pkg::udp_beat_t out_beat_o;
    wire                    out_valid_o;
    logic                   out_ready_i;
    wire udp_pkg::acknack_t ack_o [NUM_HANDLER];
    wire [NUM_HANDLER-1:0]  ack_valid_o;
    logic [NUM_HANDLER-1:0] ack_ready_i;

    logic [31:0] data_rng;
    logic [31:0] ready_rng;
    logic        random_ready;
    logic        out_hold;
    int          cycle_cnt;

    // Payload of the packet being built and the observed and expected traffic
    logic [63:0]        pkt_q[$];
    udp_pkg::udp_beat_t out_q[$];
    udp_pkg::acknack_t  ack0_q[$];
    udp_pkg::acknack_t  ack1_q[$];
    logic [63:0]        exp_hdr_q[$];
    logic [63:0]        exp_cnt_q[$];
    udp_pkg::acknack_t  exp_ack0_q[$];
    udp_pkg::acknack_t  exp_ack1_q[$];

    turf_acknack_top #(
        .NUM_HANDLER (NUM_HANDLER)
    ) DUT (
        .clk156       (clk156),
        .arst_n_i     (arst_n_i),
        .event_open_i (event_open_i),
        .in_beat_i    (in_beat_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .out_beat_o   (out_beat_o),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .ack_o        (ack_o),
        .ack_valid_o  (ack_valid_o),
        .ack_ready_i  (ack_ready_i)
    );

    initial begin
        clk156 = 1'b0;
        forever begin
            #10 clk156 = ~clk156;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_failed();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk156);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("Timeout after %0d cycles, the DUT never finished", cycle_cnt);
        stop_failed();
    end

    // Ready lines change on the falling edge and go random under back-pressure
    initial begin
        out_ready_i = 1'b1;
        ack_ready_i = '1;
        ready_rng   = SEED;
        forever begin
            @(negedge clk156);
            if (random_ready) begin
                ready_rng   = xorshift32(ready_rng);
                out_ready_i = ready_rng[3] && !out_hold;
                ack_ready_i = ready_rng[9:8];
            end else begin
                out_ready_i = 1'b1;
                ack_ready_i = '1;
            end
        end
    end

    // Sample in the middle of the low phase where everything has settled
    initial begin
        forever begin
            @(negedge clk156);
            #5;
            if (out_valid_o && out_ready_i) begin
                out_q.push_back(out_beat_o);
            end
            if (ack_valid_o[0] && ack_ready_i[0]) begin
                ack0_q.push_back(ack_o[0]);
            end
            if (ack_valid_o[1] && ack_ready_i[1]) begin
                ack1_q.push_back(ack_o[1]);
            end
        end
    end

    task automatic make_payload(input int n, input logic [63:0] mask);
        logic [63:0] w;
        pkt_q.delete();
        for (int i = 0; i < n; i++) begin
            data_rng = xorshift32(data_rng);
            w[63:32] = data_rng;
            data_rng = xorshift32(data_rng);
            w[31:0]  = data_rng;
            // Roughly half the words get the masked bits cleared
            if (w[0]) begin
                w = w & ~mask;
            end
            pkt_q.push_back(w);
        end
    endtask

    // Expected handler reaction to the packet in pkt_q
    task automatic model_packet(input logic [31:0] src_ip, input logic [15:0] src_port,
                                input logic [15:0] dst_port);
        udp_pkg::udp_hdr_t hdr;
        logic [63:0]       mask;
        logic [15:0]       count;
        int                hnd;
        hnd   = -1;
        mask  = '0;
        count = '0;
        if (dst_port == udp_pkg::ACK_PORT) begin
            hnd  = 0;
            mask = udp_pkg::ACK_CHECK_MASK;
        end else if (dst_port == udp_pkg::NACK_PORT) begin
            hnd  = 1;
            mask = udp_pkg::NACK_CHECK_MASK;
        end
        if (hnd >= 0) begin
            foreach (pkt_q[i]) begin
                if (event_open_i && ((pkt_q[i] & mask) == 64'd0)) begin
                    count = count + 16'd1;
                    if (hnd == 0) begin
                        exp_ack0_q.push_back(pkt_q[i][15:0]);
                    end else begin
                        exp_ack1_q.push_back(pkt_q[i][15:0]);
                    end
                end
            end
            hdr.src_ip   = src_ip;
            hdr.src_port = dst_port;
            hdr.dst_port = src_port;
            exp_hdr_q.push_back(hdr);
            exp_cnt_q.push_back({48'd0, count});
        end
    endtask

    // Called on a falling edge and returns on the falling edge after the transfer
    task automatic put_beat(input udp_pkg::udp_beat_t beat);
        logic taken;
        in_beat_i  = beat;
        in_valid_i = 1'b1;
        taken      = 1'b0;
        while (!taken) begin
            #5;
            taken = in_ready_o;
            @(negedge clk156);
        end
    endtask

    task automatic send_packet(input logic [31:0] src_ip, input logic [15:0] src_port,
                               input logic [15:0] dst_port);
        udp_pkg::udp_hdr_t  hdr;
        udp_pkg::udp_beat_t beat;
        hdr.src_ip   = src_ip;
        hdr.src_port = src_port;
        hdr.dst_port = dst_port;
        beat.data    = hdr;
        beat.last    = (pkt_q.size() == 0);
        put_beat(beat);
        foreach (pkt_q[i]) begin
            beat.data = pkt_q[i];
            beat.last = (i == pkt_q.size() - 1);
            put_beat(beat);
        end
        in_valid_i = 1'b0;
    endtask

    task automatic run_packet(input logic [31:0] src_ip, input logic [15:0] src_port,
                              input logic [15:0] dst_port);
        model_packet(src_ip, src_port, dst_port);
        send_packet(src_ip, src_port, dst_port);
    endtask

    task automatic check_results();
        udp_pkg::udp_beat_t hdr_beat;
        udp_pkg::udp_beat_t cnt_beat;
        int                 hit;
        int                 exp_beats;
        exp_beats = 2 * exp_hdr_q.size();
        while (out_q.size() < exp_beats || ack0_q.size() < exp_ack0_q.size() ||
               ack1_q.size() < exp_ack1_q.size()) begin
            @(negedge clk156);
        end
        // Stray beats would show up in this window
        repeat (20) @(negedge clk156);
        assert (out_q.size() == exp_beats) else begin
            $display("[ERROR] out_beat_o beats got %h expected %h", out_q.size(), exp_beats);
            stop_failed();
        end
        assert (ack0_q.size() == exp_ack0_q.size()) else begin
            $display("[ERROR] ack_o[0] words got %h expected %h",
                     ack0_q.size(), exp_ack0_q.size());
            stop_failed();
        end
        assert (ack1_q.size() == exp_ack1_q.size()) else begin
            $display("[ERROR] ack_o[1] words got %h expected %h",
                     ack1_q.size(), exp_ack1_q.size());
            stop_failed();
        end
        foreach (exp_ack0_q[i]) begin
            assert (ack0_q[i] == exp_ack0_q[i]) else begin
                $display("[ERROR] ack_o[0] got %h expected %h", ack0_q[i], exp_ack0_q[i]);
                stop_failed();
            end
        end
        foreach (exp_ack1_q[i]) begin
            assert (ack1_q[i] == exp_ack1_q[i]) else begin
                $display("[ERROR] ack_o[1] got %h expected %h", ack1_q[i], exp_ack1_q[i]);
                stop_failed();
            end
        end
        // Responses may leave in either order but never interleaved
        while (out_q.size() > 0) begin
            hdr_beat = out_q.pop_front();
            cnt_beat = out_q.pop_front();
            assert (!hdr_beat.last && cnt_beat.last) else begin
                $display("Response packet is not a header beat followed by a count beat");
                stop_failed();
            end
            hit = -1;
            foreach (exp_hdr_q[j]) begin
                if (exp_hdr_q[j] == hdr_beat.data) begin
                    hit = j;
                end
            end
            assert (hit >= 0) else begin
                $display("[ERROR] out_beat_o.data header %h matches no expected response",
                         hdr_beat.data);
                stop_failed();
            end
            assert (cnt_beat.data == exp_cnt_q[hit]) else begin
                $display("[ERROR] out_beat_o.data count got %h expected %h",
                         cnt_beat.data, exp_cnt_q[hit]);
                stop_failed();
            end
            exp_hdr_q.delete(hit);
            exp_cnt_q.delete(hit);
        end
        ack0_q.delete();
        ack1_q.delete();
        exp_ack0_q.delete();
        exp_ack1_q.delete();
    endtask

    task automatic test_ack_packet();
        @(negedge clk156);
        event_open_i = 1'b1;
        make_payload(8, udp_pkg::ACK_CHECK_MASK);
        run_packet(32'h0a000105, 16'd4000, udp_pkg::ACK_PORT);
        check_results();
    endtask

    task automatic test_nack_packet();
        @(negedge clk156);
        event_open_i = 1'b1;
        make_payload(8, udp_pkg::NACK_CHECK_MASK);
        run_packet(32'hc0a80117, 16'd5123, udp_pkg::NACK_PORT);
        check_results();
    endtask

    task automatic test_unknown_port();
        @(negedge clk156);
        event_open_i = 1'b1;
        make_payload(5, udp_pkg::ACK_CHECK_MASK);
        run_packet(32'h0a000106, 16'd4001, 16'd1234);
        make_payload(4, udp_pkg::ACK_CHECK_MASK);
        run_packet(32'h0a000107, 16'd4002, udp_pkg::ACK_PORT);
        check_results();
    endtask

    task automatic test_event_closed();
        @(negedge clk156);
        event_open_i = 1'b0;
        make_payload(6, udp_pkg::ACK_CHECK_MASK);
        run_packet(32'h0a000108, 16'd4003, udp_pkg::ACK_PORT);
        check_results();
        event_open_i = 1'b1;
    endtask

    task automatic test_back_to_back();
        // Outbound side stays stalled until both responses are waiting at the mux
        @(posedge clk156);
        random_ready = 1'b1;
        out_hold     = 1'b1;
        @(negedge clk156);
        event_open_i = 1'b1;
        make_payload(10, udp_pkg::ACK_CHECK_MASK);
        run_packet(32'h0a000109, 16'd4004, udp_pkg::ACK_PORT);
        make_payload(10, udp_pkg::NACK_CHECK_MASK);
        run_packet(32'h0a00010a, 16'd4005, udp_pkg::NACK_PORT);
        @(posedge clk156);
        out_hold = 1'b0;
        check_results();
        random_ready = 1'b0;
    endtask

    initial begin
        arst_n_i     = 1'b0;
        event_open_i = 1'b0;
        in_beat_i    = '0;
        in_valid_i   = 1'b0;
        random_ready = 1'b0;
        out_hold     = 1'b0;
        data_rng     = SEED;
        repeat (4) @(posedge clk156);
        @(negedge clk156);
        arst_n_i = 1'b1;
        test_ack_packet();
        test_nack_packet();
        test_unknown_port();
        test_event_closed();
        test_back_to_back();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
verilog/udp_pkg.sv
verilog/udp_port_switch.sv
verilog/acknack_port.sv
verilog/udp_port_mux.sv
verilog/turf_acknack_top.sv
tb/acknack_asserts.sv
tb/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_top -f tb.f -o tb_sim

./obj_dir/tb_sim
